// File: logic/video_pkg.sv
// ----------------------------------------
// Shared widths and enums of the video subsystem
// Screen codes sit below FONT_BASE_DEF, font rows from it on
// ----------------------------------------
package video_pkg;

    localparam int DATA_W        = 8;     // Memory data and register width
    localparam int MEM_ADDR_W    = 12;    // Video memory address width
    localparam int FONT_BASE_DEF = 2048;  // Default first font word

    typedef enum logic [3:0] {
        REG_H_TOTAL    = 4'd0,
        REG_H_DISP     = 4'd1,
        REG_H_SYNC_POS = 4'd2,
        REG_H_SYNC_W   = 4'd3,
        REG_V_TOTAL    = 4'd4,
        REG_V_DISP     = 4'd5,
        REG_V_SYNC_POS = 4'd6,
        REG_V_SYNC_W   = 4'd7,
        REG_CHAR_H     = 4'd8,
        REG_START_HI   = 4'd9,
        REG_START_LO   = 4'd10
    } crtc_reg_e;

    typedef enum logic [1:0] {
        OWN_NONE,
        OWN_FETCH,
        OWN_CPU
    } arb_owner_e;

    typedef enum logic [1:0] {
        F_IDLE,
        F_CODE,
        F_FONT,
        F_HOLD
    } fetch_state_e;

endpackage

// File: logic/crtc_regs.sv
// ----------------------------------------
// CRTC geometry registers, written on a one-cycle strobe
// Readback is combinational, indices 11 to 15 read zero
// ----------------------------------------
`timescale 1ns/1ns

module crtc_regs (
    input  logic                          cclk,
    input  logic                          rst_n_i,
    input  logic                          reg_we_i,
    input  video_pkg::crtc_reg_e          reg_idx_i,
    input  logic [video_pkg::DATA_W-1:0]  reg_wdata_i,
    output logic [video_pkg::DATA_W-1:0]  reg_rdata_o,
    output logic [video_pkg::DATA_W-1:0]  h_total_o,
    output logic [video_pkg::DATA_W-1:0]  h_disp_o,
    output logic [video_pkg::DATA_W-1:0]  h_sync_pos_o,
    output logic [video_pkg::DATA_W-1:0]  h_sync_w_o,
    output logic [video_pkg::DATA_W-1:0]  v_total_o,
    output logic [video_pkg::DATA_W-1:0]  v_disp_o,
    output logic [video_pkg::DATA_W-1:0]  v_sync_pos_o,
    output logic [video_pkg::DATA_W-1:0]  v_sync_w_o,
    output logic [video_pkg::DATA_W-1:0]  char_h_o,
    output logic [10:0]                   start_addr_o
);
    logic [video_pkg::DATA_W-1:0] start_hi_q;
    logic [video_pkg::DATA_W-1:0] start_lo_q;

    always_ff @(posedge cclk) begin
        if (!rst_n_i) begin
            h_total_o    <= 8'd9;   // Ten slots per line
            h_disp_o     <= 8'd8;
            h_sync_pos_o <= 8'd8;
            h_sync_w_o   <= 8'd1;
            v_total_o    <= 8'd3;   // Four character rows per frame
            v_disp_o     <= 8'd2;
            v_sync_pos_o <= 8'd2;
            v_sync_w_o   <= 8'd1;
            char_h_o     <= 8'd8;
            start_hi_q   <= '0;
            start_lo_q   <= '0;
        end else if (reg_we_i) begin
            case (reg_idx_i)
                video_pkg::REG_H_TOTAL:    h_total_o    <= reg_wdata_i;
                video_pkg::REG_H_DISP:     h_disp_o     <= reg_wdata_i;
                video_pkg::REG_H_SYNC_POS: h_sync_pos_o <= reg_wdata_i;
                video_pkg::REG_H_SYNC_W:   h_sync_w_o   <= reg_wdata_i;
                video_pkg::REG_V_TOTAL:    v_total_o    <= reg_wdata_i;
                video_pkg::REG_V_DISP:     v_disp_o     <= reg_wdata_i;
                video_pkg::REG_V_SYNC_POS: v_sync_pos_o <= reg_wdata_i;
                video_pkg::REG_V_SYNC_W:   v_sync_w_o   <= reg_wdata_i;
                video_pkg::REG_CHAR_H:     char_h_o     <= reg_wdata_i;
                video_pkg::REG_START_HI:   start_hi_q   <= reg_wdata_i;
                video_pkg::REG_START_LO:   start_lo_q   <= reg_wdata_i;
                default: ;                                  // Unused index
            endcase
        end
    end

    always_comb begin
        case (reg_idx_i)
            video_pkg::REG_H_TOTAL:    reg_rdata_o = h_total_o;
            video_pkg::REG_H_DISP:     reg_rdata_o = h_disp_o;
            video_pkg::REG_H_SYNC_POS: reg_rdata_o = h_sync_pos_o;
            video_pkg::REG_H_SYNC_W:   reg_rdata_o = h_sync_w_o;
            video_pkg::REG_V_TOTAL:    reg_rdata_o = v_total_o;
            video_pkg::REG_V_DISP:     reg_rdata_o = v_disp_o;
            video_pkg::REG_V_SYNC_POS: reg_rdata_o = v_sync_pos_o;
            video_pkg::REG_V_SYNC_W:   reg_rdata_o = v_sync_w_o;
            video_pkg::REG_CHAR_H:     reg_rdata_o = char_h_o;
            video_pkg::REG_START_HI:   reg_rdata_o = start_hi_q;
            video_pkg::REG_START_LO:   reg_rdata_o = start_lo_q;
            default:                   reg_rdata_o = '0;
        endcase
    end

    assign start_addr_o = {start_hi_q[2:0], start_lo_q};  // 2K screen window

endmodule

// File: logic/crtc_sync_gen.sv
// ----------------------------------------
// Pixel, column, scanline and row counters
// Outputs describe the slot now running, not yet delayed
// ----------------------------------------
`timescale 1ns/1ns

module crtc_sync_gen (
    input  logic                          cclk,
    input  logic                          rst_n_i,
    input  logic [video_pkg::DATA_W-1:0]  h_total_i,
    input  logic [video_pkg::DATA_W-1:0]  h_disp_i,
    input  logic [video_pkg::DATA_W-1:0]  h_sync_pos_i,
    input  logic [video_pkg::DATA_W-1:0]  h_sync_w_i,
    input  logic [video_pkg::DATA_W-1:0]  v_total_i,
    input  logic [video_pkg::DATA_W-1:0]  v_disp_i,
    input  logic [video_pkg::DATA_W-1:0]  v_sync_pos_i,
    input  logic [video_pkg::DATA_W-1:0]  v_sync_w_i,
    input  logic [video_pkg::DATA_W-1:0]  char_h_i,
    input  logic [10:0]                   start_addr_i,
    output logic                          char_tick_o,
    output logic [10:0]                   ma_o,
    output logic [2:0]                    ra_o,
    output logic                          de_o,
    output logic                          hs_o,
    output logic                          vs_o
);
    logic [2:0]                   pix_q;
    logic [video_pkg::DATA_W-1:0] col_q;
    logic [video_pkg::DATA_W-1:0] scan_q;
    logic [video_pkg::DATA_W-1:0] row_q;
    logic [10:0]                  row_start_q;
    logic                         last_col;
    logic                         last_scan;
    logic                         last_row;

    assign char_tick_o = (pix_q == 3'd7);
    assign last_col    = (col_q >= h_total_i);
    assign last_scan   = (scan_q + 8'd1 >= char_h_i);
    assign last_row    = (row_q >= v_total_i);

    always_ff @(posedge cclk) begin
        if (!rst_n_i) begin
            pix_q       <= '0;
            col_q       <= '0;
            scan_q      <= '0;
            row_q       <= '0;
            row_start_q <= '0;
        end else begin
            pix_q <= pix_q + 3'd1;
            if (char_tick_o) begin
                col_q <= last_col ? '0 : col_q + 8'd1;
                if (last_col) begin
                    scan_q <= last_scan ? '0 : scan_q + 8'd1;
                    if (last_scan && last_row) begin
                        row_q       <= '0;
                        row_start_q <= start_addr_i;  // New frame picks up the start address
                    end else if (last_scan) begin
                        row_q       <= row_q + 8'd1;
                        row_start_q <= row_start_q + {3'b0, h_disp_i};
                    end
                end
            end
        end
    end

    assign ma_o = row_start_q + {3'b0, col_q};
    assign ra_o = scan_q[2:0];
    assign de_o = (col_q < h_disp_i) && (row_q < v_disp_i);

    // Offset compare keeps the window correct near the top of the count range
    assign hs_o = (col_q >= h_sync_pos_i) && ((col_q - h_sync_pos_i) < h_sync_w_i);
    assign vs_o = (row_q >= v_sync_pos_i) && ((row_q - v_sync_pos_i) < v_sync_w_i);

    // Each new scanline starts inside the character height
    a_scan_in_range: assert property (@(posedge cclk) disable iff (!rst_n_i)
        (char_tick_o && last_col && $stable(char_h_i)) |=>
            (char_h_i == 8'd0 || scan_q < char_h_i));

endmodule

// File: logic/char_fetch.sv
// ----------------------------------------
// Fetches screen code then font row once per displayed slot
// Relies on the arbiter granting it in the cycle it asks
// ----------------------------------------
`timescale 1ns/1ns

module char_fetch #(
    parameter int FONT_BASE = video_pkg::FONT_BASE_DEF
) (
    input  logic                              cclk,
    input  logic                              rst_n_i,
    input  logic                              char_tick_i,
    input  logic [10:0]                       ma_i,
    input  logic [2:0]                        ra_i,
    input  logic                              de_i,
    input  logic                              fetch_ready_i,
    input  logic [video_pkg::DATA_W-1:0]      fetch_rdata_i,
    input  logic                              fetch_rvalid_i,
    output logic                              fetch_valid_o,
    output logic                              fetch_we_o,
    output logic [video_pkg::MEM_ADDR_W-1:0]  fetch_addr_o,
    output logic [video_pkg::DATA_W-1:0]      row_bits_o,
    output logic                              reverse_o
);
    localparam logic [video_pkg::MEM_ADDR_W-1:0] FONT_ADDR =
        FONT_BASE[video_pkg::MEM_ADDR_W-1:0];

    video_pkg::fetch_state_e      state_q;
    video_pkg::fetch_state_e      state_d;
    logic                         slot_start_q;  // Cycle 0 of a slot
    logic [video_pkg::DATA_W-1:0] code_q;

    always_comb begin
        state_d       = state_q;
        fetch_valid_o = 1'b0;
        fetch_addr_o  = {1'b0, ma_i};
        case (state_q)
            video_pkg::F_IDLE, video_pkg::F_HOLD: begin
                if (slot_start_q && de_i) begin
                    fetch_valid_o = 1'b1;            // Screen code request
                    if (fetch_ready_i) begin
                        state_d = video_pkg::F_CODE;
                    end
                end else if (slot_start_q) begin
                    state_d = video_pkg::F_IDLE;     // Blank slot
                end
            end
            video_pkg::F_CODE: begin
                if (fetch_rvalid_i) begin
                    state_d = video_pkg::F_FONT;
                end
            end
            video_pkg::F_FONT: begin
                fetch_valid_o = 1'b1;
                fetch_addr_o  = FONT_ADDR + {2'b0, code_q[6:0], ra_i};
                if (fetch_ready_i) begin
                    state_d = video_pkg::F_HOLD;
                end
            end
            default: state_d = video_pkg::F_IDLE;
        endcase
    end

    always_ff @(posedge cclk) begin
        if (!rst_n_i) begin
            state_q      <= video_pkg::F_IDLE;
            slot_start_q <= 1'b1;                    // Counters start at pixel 0
        end else begin
            state_q      <= state_d;
            slot_start_q <= char_tick_i;
        end
    end

    always_ff @(posedge cclk) begin
        if (state_q == video_pkg::F_CODE && fetch_rvalid_i) begin
            code_q <= fetch_rdata_i;
        end
        if (state_q == video_pkg::F_HOLD && fetch_rvalid_i) begin
            row_bits_o <= fetch_rdata_i;             // Font row arrives in cycle 3
        end
    end

    assign fetch_we_o = 1'b0;
    assign reverse_o  = code_q[7];

    // Both reads finish before the shifter loads
    a_done_by_tick: assert property (@(posedge cclk) disable iff (!rst_n_i)
        char_tick_i |-> (state_q == video_pkg::F_HOLD || state_q == video_pkg::F_IDLE));

endmodule

// File: logic/mem_arbiter.sv
// ----------------------------------------
// Fixed priority arbiter, fetcher first
// Read data returns one cycle after the grant
// ----------------------------------------
`timescale 1ns/1ns

module mem_arbiter (
    input  logic                              cclk,
    input  logic                              rst_n_i,
    input  logic                              fetch_valid_i,
    input  logic                              fetch_we_i,
    input  logic [video_pkg::MEM_ADDR_W-1:0]  fetch_addr_i,
    output logic                              fetch_ready_o,
    output logic [video_pkg::DATA_W-1:0]      fetch_rdata_o,
    output logic                              fetch_rvalid_o,
    input  logic                              cpu_valid_i,
    input  logic                              cpu_we_i,
    input  logic [video_pkg::MEM_ADDR_W-1:0]  cpu_addr_i,
    input  logic [video_pkg::DATA_W-1:0]      cpu_wdata_i,
    output logic                              cpu_ready_o,
    output logic [video_pkg::DATA_W-1:0]      cpu_rdata_o,
    output logic                              cpu_rvalid_o,
    input  logic [video_pkg::DATA_W-1:0]      mem_rdata_i,
    output logic                              mem_en_o,
    output logic                              mem_we_o,
    output logic [video_pkg::MEM_ADDR_W-1:0]  mem_addr_o,
    output logic [video_pkg::DATA_W-1:0]      mem_wdata_o
);
    video_pkg::arb_owner_e owner_q;

    assign fetch_ready_o = fetch_valid_i;
    assign cpu_ready_o   = cpu_valid_i && !fetch_valid_i;  // CPU waits while fetcher asks

    assign mem_en_o    = fetch_valid_i || cpu_valid_i;
    assign mem_we_o    = fetch_valid_i ? fetch_we_i : cpu_we_i;
    assign mem_addr_o  = fetch_valid_i ? fetch_addr_i : cpu_addr_i;
    assign mem_wdata_o = cpu_wdata_i;

    always_ff @(posedge cclk) begin
        if (!rst_n_i) begin
            owner_q <= video_pkg::OWN_NONE;
        end else if (fetch_valid_i && !fetch_we_i) begin
            owner_q <= video_pkg::OWN_FETCH;
        end else if (cpu_ready_o && !cpu_we_i) begin
            owner_q <= video_pkg::OWN_CPU;
        end else begin
            owner_q <= video_pkg::OWN_NONE;    // Writes return nothing
        end
    end

    assign fetch_rvalid_o = (owner_q == video_pkg::OWN_FETCH);
    assign cpu_rvalid_o   = (owner_q == video_pkg::OWN_CPU);
    assign fetch_rdata_o  = mem_rdata_i;
    assign cpu_rdata_o    = mem_rdata_i;

    a_one_grant: assert property (@(posedge cclk) disable iff (!rst_n_i)
        $onehot0({fetch_valid_i && fetch_ready_o, cpu_valid_i && cpu_ready_o}));

    a_cpu_rvalid: assert property (@(posedge cclk) disable iff (!rst_n_i)
        (cpu_valid_i && cpu_ready_o && !cpu_we_i) |=> cpu_rvalid_o);

    a_fetch_rvalid: assert property (@(posedge cclk) disable iff (!rst_n_i)
        (fetch_valid_i && fetch_ready_o && !fetch_we_i) |=> fetch_rvalid_o);

endmodule

// File: logic/video_mem.sv
// ----------------------------------------
// Single-port video memory, read before write
// Read data is valid the cycle after the enable
// ----------------------------------------
`timescale 1ns/1ns

module video_mem #(
    parameter int MEM_WORDS = 4096
) (
    input  logic                              cclk,
    input  logic                              mem_en_i,
    input  logic                              mem_we_i,
    input  logic [video_pkg::MEM_ADDR_W-1:0]  mem_addr_i,
    input  logic [video_pkg::DATA_W-1:0]      mem_wdata_i,
    output logic [video_pkg::DATA_W-1:0]      mem_rdata_o
);
    logic [video_pkg::DATA_W-1:0] mem_q [MEM_WORDS];

    always_ff @(posedge cclk) begin
        if (mem_en_i) begin
            mem_rdata_o <= mem_q[mem_addr_i];  // Old contents on a write
            if (mem_we_i) begin
                mem_q[mem_addr_i] <= mem_wdata_i;
            end
        end
    end

endmodule

// File: logic/dot_shifter.sv
// ----------------------------------------
// Serialises one font row per slot, MSB first
// Delays de and syncs by one slot to match the pixels
// ----------------------------------------
`timescale 1ns/1ns

module dot_shifter (
    input  logic                          cclk,
    input  logic                          rst_n_i,
    input  logic                          char_tick_i,
    input  logic                          de_i,
    input  logic                          hs_i,
    input  logic                          vs_i,
    input  logic [video_pkg::DATA_W-1:0]  row_bits_i,
    input  logic                          reverse_i,
    output logic                          video_o,
    output logic                          display_enable_o,
    output logic                          hsync_o,
    output logic                          vsync_o
);
    logic [video_pkg::DATA_W-1:0] shift_q;

    always_ff @(posedge cclk) begin
        if (char_tick_i) begin
            shift_q <= reverse_i ? ~row_bits_i : row_bits_i;
        end else begin
            shift_q <= shift_q << 1;
        end
    end

    always_ff @(posedge cclk) begin
        if (!rst_n_i) begin
            display_enable_o <= 1'b0;
            hsync_o          <= 1'b0;
            vsync_o          <= 1'b0;
        end else if (char_tick_i) begin
            display_enable_o <= de_i;
            hsync_o          <= hs_i;
            vsync_o          <= vs_i;
        end
    end

    assign video_o = display_enable_o && shift_q[video_pkg::DATA_W-1];  // Blank outside display

endmodule

// File: logic/video_top.sv
// ----------------------------------------
// Character video subsystem top, one pixel per cclk
// CPU memory reads stall at most two cycles
// ----------------------------------------
`timescale 1ns/1ns

module video_top #(
    parameter int FONT_BASE = video_pkg::FONT_BASE_DEF,
    parameter int MEM_WORDS = 4096
) (
    input  logic                              cclk,
    input  logic                              rst_n_i,
    input  logic                              reg_we_i,
    input  video_pkg::crtc_reg_e              reg_idx_i,
    input  logic [video_pkg::DATA_W-1:0]      reg_wdata_i,
    output logic [video_pkg::DATA_W-1:0]      reg_rdata_o,
    input  logic                              cpu_valid_i,
    output logic                              cpu_ready_o,
    input  logic                              cpu_we_i,
    input  logic [video_pkg::MEM_ADDR_W-1:0]  cpu_addr_i,
    input  logic [video_pkg::DATA_W-1:0]      cpu_wdata_i,
    output logic [video_pkg::DATA_W-1:0]      cpu_rdata_o,
    output logic                              cpu_rvalid_o,
    output logic                              hsync_o,
    output logic                              vsync_o,
    output logic                              video_o,
    output logic                              display_enable_o
);
    logic [video_pkg::DATA_W-1:0]     h_total, h_disp, h_sync_pos, h_sync_w;
    logic [video_pkg::DATA_W-1:0]     v_total, v_disp, v_sync_pos, v_sync_w;
    logic [video_pkg::DATA_W-1:0]     char_h;
    logic [10:0]                      start_addr;
    logic                             char_tick, de, hs, vs;
    logic [10:0]                      ma;
    logic [2:0]                       ra;
    logic                             fetch_valid, fetch_we, fetch_ready, fetch_rvalid;
    logic [video_pkg::MEM_ADDR_W-1:0] fetch_addr, mem_addr;
    logic [video_pkg::DATA_W-1:0]     fetch_rdata, row_bits, mem_rdata, mem_wdata;
    logic                             reverse, mem_en, mem_we;

    crtc_regs i_regs (
        .cclk, .rst_n_i, .reg_we_i, .reg_idx_i, .reg_wdata_i, .reg_rdata_o,
        .h_total_o(h_total), .h_disp_o(h_disp), .h_sync_pos_o(h_sync_pos),
        .h_sync_w_o(h_sync_w), .v_total_o(v_total), .v_disp_o(v_disp),
        .v_sync_pos_o(v_sync_pos), .v_sync_w_o(v_sync_w), .char_h_o(char_h),
        .start_addr_o(start_addr)
    );

    crtc_sync_gen i_sync (
        .cclk, .rst_n_i,
        .h_total_i(h_total), .h_disp_i(h_disp), .h_sync_pos_i(h_sync_pos),
        .h_sync_w_i(h_sync_w), .v_total_i(v_total), .v_disp_i(v_disp),
        .v_sync_pos_i(v_sync_pos), .v_sync_w_i(v_sync_w), .char_h_i(char_h),
        .start_addr_i(start_addr), .char_tick_o(char_tick), .ma_o(ma), .ra_o(ra),
        .de_o(de), .hs_o(hs), .vs_o(vs)
    );

    char_fetch #(.FONT_BASE(FONT_BASE)) i_fetch (
        .cclk, .rst_n_i, .char_tick_i(char_tick), .ma_i(ma), .ra_i(ra), .de_i(de),
        .fetch_ready_i(fetch_ready), .fetch_rdata_i(fetch_rdata),
        .fetch_rvalid_i(fetch_rvalid), .fetch_valid_o(fetch_valid),
        .fetch_we_o(fetch_we), .fetch_addr_o(fetch_addr),
        .row_bits_o(row_bits), .reverse_o(reverse)
    );

    mem_arbiter i_arb (
        .cclk, .rst_n_i,
        .fetch_valid_i(fetch_valid), .fetch_we_i(fetch_we), .fetch_addr_i(fetch_addr),
        .fetch_ready_o(fetch_ready), .fetch_rdata_o(fetch_rdata),
        .fetch_rvalid_o(fetch_rvalid),
        .cpu_valid_i, .cpu_we_i, .cpu_addr_i, .cpu_wdata_i,
        .cpu_ready_o, .cpu_rdata_o, .cpu_rvalid_o,
        .mem_rdata_i(mem_rdata), .mem_en_o(mem_en), .mem_we_o(mem_we),
        .mem_addr_o(mem_addr), .mem_wdata_o(mem_wdata)
    );

    video_mem #(.MEM_WORDS(MEM_WORDS)) i_mem (
        .cclk, .mem_en_i(mem_en), .mem_we_i(mem_we), .mem_addr_i(mem_addr),
        .mem_wdata_i(mem_wdata), .mem_rdata_o(mem_rdata)
    );

    dot_shifter i_dots (
        .cclk, .rst_n_i, .char_tick_i(char_tick), .de_i(de), .hs_i(hs), .vs_i(vs),
        .row_bits_i(row_bits), .reverse_i(reverse), .video_o, .display_enable_o,
        .hsync_o, .vsync_o
    );

endmodule

// File: verification/video_tb.sv
// ----------------------------------------
// Directed tests of video_top with default parameters
// Inputs change on the falling edge, outputs are sampled there
// ----------------------------------------
`timescale 1ns/1ns

module video_tb;
    typedef logic [video_pkg::DATA_W-1:0]     byte_t;
    typedef logic [video_pkg::MEM_ADDR_W-1:0] addr_t;

    localparam int TIMEOUT    = 5000;  // Cycles allowed for any single wait
    localparam int H_TOTAL    = 5;
    localparam int H_DISP     = 4;
    localparam int H_SYNC_POS = 4;
    localparam int H_SYNC_W   = 2;
    localparam int V_TOTAL    = 3;
    localparam int V_DISP     = 2;
    localparam int V_SYNC_POS = 2;
    localparam int V_SYNC_W   = 1;
    localparam int CHAR_H     = 3;
    localparam int START      = 16;    // Screen start address

    logic                 cclk;
    logic                 rst_n_i;
    logic                 reg_we_i;
    video_pkg::crtc_reg_e reg_idx_i;
    byte_t                reg_wdata_i, reg_rdata_o;
    logic                 cpu_valid_i, cpu_ready_o, cpu_we_i, cpu_rvalid_o;
    addr_t                cpu_addr_i;
    byte_t                cpu_wdata_i, cpu_rdata_o;
    logic                 hsync_o, vsync_o, video_o, display_enable_o;
    byte_t                shadow [1 << video_pkg::MEM_ADDR_W];  // Expected memory contents
    int                   mismatches;
    int                   failures;
    logic                 frame_done;

    video_top i_dut (.*);

    initial begin
        cclk = 1'b0;
        forever #2 cclk = ~cclk;
    end

    function automatic byte_t rand_byte();
        return byte_t'($urandom);
    endfunction

    task automatic check_byte(string name, byte_t exp, byte_t act);
        if (act !== exp) begin
            $display("MISMATCH at %0t ns: %s expected 0x%02h, got 0x%02h", $time, name, exp, act);
            mismatches++;
        end
    endtask

    task automatic check_bit(string name, logic exp, logic act);
        if (act !== exp) begin
            $display("MISMATCH at %0t ns: %s expected %b, got %b", $time, name, exp, act);
            mismatches++;
        end
    endtask

    task automatic check_count(string name, int exp, int act);
        if (act != exp) begin
            $display("MISMATCH at %0t ns: %s expected %0d cycles, got %0d", $time, name, exp, act);
            mismatches++;
        end
    endtask

    task automatic note_failure(string msg);
        $display("ERROR at %0t ns: %s", $time, msg);
        failures++;
    endtask

    task automatic write_reg(video_pkg::crtc_reg_e idx, byte_t data);
        reg_we_i    = 1'b1;
        reg_idx_i   = idx;
        reg_wdata_i = data;
        @(negedge cclk);
        reg_we_i = 1'b0;
    endtask

    // Starts at a falling edge and returns at the falling edge after the transfer
    task automatic cpu_access(logic we, addr_t addr, byte_t wdata);
        int waits;
        cpu_valid_i = 1'b1;
        cpu_we_i    = we;
        cpu_addr_i  = addr;
        cpu_wdata_i = wdata;
        waits       = 0;
        #1;
        while (!cpu_ready_o && waits < TIMEOUT) begin
            @(negedge cclk);
            #1;
            waits++;
        end
        if (!cpu_ready_o) begin
            note_failure($sformatf("CPU request to 0x%03h was never accepted", addr));
            cpu_valid_i = 1'b0;
            return;
        end
        if (waits + 1 > 3)
            note_failure($sformatf("CPU request to 0x%03h took %0d cycles", addr, waits + 1));
        if (we)
            shadow[addr] = wdata;
        @(negedge cclk);
        check_bit("cpu_rvalid_o", !we, cpu_rvalid_o);  // Pulses only after a read
        if (!we)
            check_byte($sformatf("cpu_rdata_o[0x%03h]", addr), shadow[addr], cpu_rdata_o);
    endtask

    task automatic wait_change(logic use_vsync, logic level, output int cycles, output bit ok);
        logic prev;
        logic cur;
        int   n;
        prev = use_vsync ? vsync_o : hsync_o;
        n    = 0;
        ok   = 1'b0;
        while (n < TIMEOUT && !ok) begin
            @(negedge cclk);
            n++;
            cur = use_vsync ? vsync_o : hsync_o;
            ok  = (cur == level) && (prev != level);
            prev = cur;
        end
        cycles = n;
        if (!ok)
            note_failure($sformatf("timed out waiting for %s to go %b",
                                   use_vsync ? "vsync_o" : "hsync_o", level));
    endtask

    // Blank cycles must keep video low
    task automatic wait_de_high(output bit ok);
        int n;
        ok = 1'b0;
        for (n = 0; n < TIMEOUT && !ok; n++) begin
            @(negedge cclk);
            ok = display_enable_o;
            if (!ok)
                check_bit("video_o while blank", 1'b0, video_o);
        end
        if (!ok)
            note_failure("timed out waiting for display_enable_o");
    endtask

    function automatic logic predict_pixel(int line, int x);
        int    addr;
        byte_t code;
        byte_t font;
        code = shadow[addr_t'(START + (line / CHAR_H) * H_DISP + x / 8)];
        addr = video_pkg::FONT_BASE_DEF + int'(code[6:0]) * 8 + line % CHAR_H;
        font = shadow[addr_t'(addr)];
        return font[video_pkg::DATA_W - 1 - x % 8] ^ code[7];  // MSB first
    endfunction

    task automatic check_frame();
        int n;
        int line;
        int x;
        bit got;
        wait_change(1'b1, 1'b1, n, got);  // Next de after vsync is row 0
        for (line = 0; line < V_DISP * CHAR_H && got; line++) begin
            wait_de_high(got);
            for (x = 0; x < H_DISP * 8 && got; x++) begin
                if (x > 0)
                    @(negedge cclk);
                check_bit("display_enable_o", 1'b1, display_enable_o);
                check_bit($sformatf("video_o line %0d x %0d", line, x),
                          predict_pixel(line, x), video_o);
            end
        end
    endtask

    task automatic test_registers();
        byte_t vals [16];
        byte_t expv;
        int    i;
        @(negedge cclk);
        for (i = 0; i < 16; i++) begin
            vals[i] = rand_byte();
            write_reg(video_pkg::crtc_reg_e'(i), vals[i]);
        end
        for (i = 0; i < 16; i++) begin
            reg_idx_i = video_pkg::crtc_reg_e'(i);
            expv      = (i <= int'(video_pkg::REG_START_LO)) ? vals[i] : '0;
            #1;
            check_byte($sformatf("reg_rdata_o[%0d]", i), expv, reg_rdata_o);
            @(negedge cclk);
        end
    endtask

    task automatic test_memory();
        addr_t addrs [8];
        int    off;
        int    i;
        @(negedge cclk);
        for (i = 0; i < 8; i++) begin
            off = int'($urandom % 32'd2048);
            if (i % 2 == 0)
                addrs[i] = addr_t'(off);                              // Screen area
            else
                addrs[i] = addr_t'(video_pkg::FONT_BASE_DEF + off);   // Font area
            cpu_access(1'b1, addrs[i], rand_byte());
        end
        for (i = 0; i < 8; i++)
            cpu_access(1'b0, addrs[i], '0);
        cpu_valid_i = 1'b0;
    endtask

    task automatic test_sync();
        int high;
        int low;
        int period;
        bit got;
        @(negedge cclk);
        write_reg(video_pkg::REG_H_TOTAL, byte_t'(H_TOTAL));
        write_reg(video_pkg::REG_H_DISP, byte_t'(H_DISP));
        write_reg(video_pkg::REG_H_SYNC_POS, byte_t'(H_SYNC_POS));
        write_reg(video_pkg::REG_H_SYNC_W, byte_t'(H_SYNC_W));
        write_reg(video_pkg::REG_V_TOTAL, byte_t'(V_TOTAL));
        write_reg(video_pkg::REG_V_DISP, byte_t'(V_DISP));
        write_reg(video_pkg::REG_V_SYNC_POS, byte_t'(V_SYNC_POS));
        write_reg(video_pkg::REG_V_SYNC_W, byte_t'(V_SYNC_W));
        write_reg(video_pkg::REG_CHAR_H, byte_t'(CHAR_H));
        write_reg(video_pkg::REG_START_HI, byte_t'(START / 256));
        write_reg(video_pkg::REG_START_LO, byte_t'(START % 256));
        wait_change(1'b1, 1'b1, period, got);  // Two frames to flush the old geometry
        wait_change(1'b1, 1'b1, period, got);
        wait_change(1'b1, 1'b1, period, got);
        check_count("vsync_o period", (H_TOTAL + 1) * 8 * (V_TOTAL + 1) * CHAR_H, period);
        wait_change(1'b0, 1'b1, high, got);
        wait_change(1'b0, 1'b0, high, got);
        wait_change(1'b0, 1'b1, low, got);
        check_count("hsync_o high time", H_SYNC_W * 8, high);
        check_count("hsync_o period", (H_TOTAL + 1) * 8, high + low);
    endtask

    // Every second cell has bit 7 set
    task automatic test_pixels();
        byte_t code;
        int    c;
        int    r;
        @(negedge cclk);
        for (c = 0; c < H_DISP * V_DISP; c++) begin
            code    = rand_byte();
            code[7] = (c % 2 == 1);
            cpu_access(1'b1, addr_t'(START + c), code);
            for (r = 0; r < CHAR_H; r++)
                cpu_access(1'b1, addr_t'(video_pkg::FONT_BASE_DEF + int'(code[6:0]) * 8 + r),
                           rand_byte());
        end
        cpu_valid_i = 1'b0;
        check_frame();
    endtask

    task automatic test_reverse();
        int c;
        @(negedge cclk);
        for (c = 0; c < H_DISP * V_DISP; c++)
            cpu_access(1'b1, addr_t'(START + c), shadow[addr_t'(START + c)] ^ 8'h80);
        cpu_valid_i = 1'b0;
        check_frame();
    endtask

    task automatic test_contention();
        int    n;
        addr_t addr;
        frame_done = 1'b0;
        @(negedge cclk);
        fork
            begin
                check_frame();
                frame_done = 1'b1;
            end
            begin
                for (n = 0; !frame_done && n < 4 * TIMEOUT; n++) begin
                    addr = addr_t'(1024 + (n / 2) % 32);  // Off the visible screen
                    if (n % 2 == 0)
                        cpu_access(1'b1, addr, rand_byte());
                    else
                        cpu_access(1'b0, addr, '0);
                end
                cpu_valid_i = 1'b0;
            end
        join
    endtask

    initial begin
        void'($urandom(32'hf3632f0c));
        mismatches  = 0;
        failures    = 0;
        frame_done  = 1'b0;
        rst_n_i     = 1'b0;
        reg_we_i    = 1'b0;
        reg_idx_i   = video_pkg::REG_H_TOTAL;
        reg_wdata_i = '0;
        cpu_valid_i = 1'b0;
        cpu_we_i    = 1'b0;
        cpu_addr_i  = '0;
        cpu_wdata_i = '0;
        repeat (3) @(negedge cclk);
        rst_n_i = 1'b1;
        check_bit("hsync_o", 1'b0, hsync_o);
        check_bit("vsync_o", 1'b0, vsync_o);
        check_bit("video_o", 1'b0, video_o);
        check_bit("display_enable_o", 1'b0, display_enable_o);
        check_bit("cpu_ready_o", 1'b0, cpu_ready_o);
        check_bit("cpu_rvalid_o", 1'b0, cpu_rvalid_o);
        test_registers();
        test_memory();
        test_sync();
        test_pixels();
        test_reverse();
        test_contention();
        $display("Summary: %0d mismatches, %0d other errors", mismatches, failures);
        if (mismatches == 0 && failures == 0)
            $display("RESULT: PASS");
        else
            $display("RESULT: FAIL");
        $finish;
    end

endmodule

// File: project.f
logic/video_pkg.sv
logic/crtc_regs.sv
logic/crtc_sync_gen.sv
logic/char_fetch.sv
logic/mem_arbiter.sv
logic/video_mem.sv
logic/dot_shifter.sv
logic/video_top.sv
verification/video_tb.sv

// File: Makefile
TOOL     := verilator
FLAGS    := --binary --timing --assert --timescale 1ns/1ns
TOP      := video_tb
FILELIST := project.f
BUILD    := obj_dir
LOG      := sim.log

.PHONY: sim clean

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)
	./$(BUILD)/V$(TOP) | tee $(LOG)
	grep -q "RESULT: PASS" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)
